/* source/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Basic word types
	////////////////////////////////////////////////////////////////////////////

	// CPU address, one 16-bit word address
	typedef logic [15:0] addr_t;

	// Data word moved on every access
	typedef logic [15:0] data_t;

	// Target of a CPU access
	typedef enum logic [2:0] {
		REGION_RAM1,
		REGION_RAM2,
		REGION_UART_DATA,
		REGION_UART_STAT,
		REGION_CFG
	} region_e;

	////////////////////////////////////////////////////////////////////////////
	// Register block in the top page
	////////////////////////////////////////////////////////////////////////////

	localparam addr_t UART_DATA_ADDR = 16'hBF00;
	localparam addr_t UART_STAT_ADDR = 16'hBF01;
	localparam addr_t CFG_ADDR       = 16'hBF02;

	// Wait states added by each bank
	typedef struct packed {
		logic [3:0] ram1_wait;
		logic [3:0] ram2_wait;
	} wait_cfg_t;

endpackage

`default_nettype wire

/* source/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic bundles
	////////////////////////////////////////////////////////////////////////////

	// Master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		mem_map_pkg::addr_t  adr;
		mem_map_pkg::data_t  dat;
	} wb_req_t;

	// Slave to master, ack is a single-cycle pulse
	typedef struct packed {
		mem_map_pkg::data_t  dat;
		logic                ack;
	} wb_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// Router FSM
	////////////////////////////////////////////////////////////////////////////

	// IDLE decodes, WAIT holds the downstream request, RESPOND acks the CPU
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RESPOND
	} router_state_e;

endpackage

`default_nettype wire

/* source/ram_bank.sv */
`default_nettype none

module ram_bank #(
	parameter int RAM_DEPTH_LOG2 = 10
) (
	input  wire                      ram1_work_done,
	input  wire                      reset,
	input  wire bus_pkg::wb_req_t    bank_req,
	output bus_pkg::wb_rsp_t         bank_rsp,
	input  wire [3:0]                wait_count
);

	localparam int DEPTH = 1 << RAM_DEPTH_LOG2;

	mem_map_pkg::data_t        mem [DEPTH];
	mem_map_pkg::data_t        rd_q;
	logic [3:0]                wait_cnt;
	logic                      ack_q;
	logic                      req_live;
	logic                      access;
	logic [RAM_DEPTH_LOG2-1:0] word_addr;

	// Upper address bits dropped, so the bank aliases within its half
	assign word_addr = bank_req.adr[RAM_DEPTH_LOG2-1:0];

	// A request stays live until it has been acknowledged once
	assign req_live = bank_req.cyc && bank_req.stb && !ack_q;

	// Access happens once the wait states have elapsed
	assign access = req_live && (wait_cnt >= wait_count);

	////////////////////////////////////////////////////////////////////////////
	// Wait-state counter and ack
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
		end else if (ack_q) begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
		end else if (access) begin
			ack_q <= 1'b1;
		end else if (req_live) begin
			wait_cnt <= wait_cnt + 4'd1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// Word storage
	always_ff @(posedge ram1_work_done) begin
		if (access) begin
			if (bank_req.we) begin
				mem[word_addr] <= bank_req.dat;
			end else begin
				rd_q <= mem[word_addr];
			end
		end
	end

	// Read data is valid together with the ack
	assign bank_rsp = '{dat: rd_q, ack: ack_q};

endmodule

`default_nettype wire

/* source/uart_cfg_regs.sv */
`default_nettype none

module uart_cfg_regs (
	input  wire                        ram1_work_done,
	input  wire                        reset,
	input  wire bus_pkg::wb_req_t      reg_req,
	output bus_pkg::wb_rsp_t           reg_rsp,
	input  wire [7:0]                  rx_byte,
	input  wire                        rx_strobe,
	output logic [7:0]                 tx_byte,
	output logic                       tx_strobe,
	output mem_map_pkg::wait_cfg_t     wait_cfg
);

	logic               ack_q;
	logic               access;
	logic               rx_valid;
	logic [7:0]         rx_data;
	logic               data_hit;
	logic               cfg_hit;
	mem_map_pkg::data_t rd_d;
	mem_map_pkg::data_t rd_q;

	assign access   = reg_req.cyc && reg_req.stb && !ack_q;
	assign data_hit = (reg_req.adr == mem_map_pkg::UART_DATA_ADDR);
	assign cfg_hit  = (reg_req.adr == mem_map_pkg::CFG_ADDR);

	// Read mux
	always_comb begin
		case (reg_req.adr)
			mem_map_pkg::UART_DATA_ADDR: rd_d = {8'h00, rx_data};
			// Transmitter always ready in bit 0
			mem_map_pkg::UART_STAT_ADDR: rd_d = {12'hFFF, 1'b0, 1'b1, rx_valid, 1'b1};
			mem_map_pkg::CFG_ADDR:       rd_d = {8'h00, wait_cfg};
			default:                     rd_d = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			ack_q     <= 1'b0;
			tx_strobe <= 1'b0;
			rx_valid  <= 1'b0;
			wait_cfg  <= '0;
		end else begin
			ack_q     <= access;
			tx_strobe <= access && reg_req.we && data_hit;
			if (access && reg_req.we && cfg_hit) begin
				wait_cfg <= mem_map_pkg::wait_cfg_t'(reg_req.dat[7:0]);
			end
			// A new byte wins over a read in the same cycle
			if (rx_strobe) begin
				rx_valid <= 1'b1;
			end else if (access && !reg_req.we && data_hit) begin
				rx_valid <= 1'b0;
			end
		end
	end

	// Data latches
	always_ff @(posedge ram1_work_done) begin
		if (rx_strobe) begin
			rx_data <= rx_byte;
		end
		if (access) begin
			rd_q <= rd_d;
		end
		if (access && reg_req.we && data_hit) begin
			tx_byte <= reg_req.dat[7:0];
		end
	end

	assign reg_rsp = '{dat: rd_q, ack: ack_q};

endmodule

`default_nettype wire

/* source/mem_router.sv */
`default_nettype none

module mem_router (
	input  wire                      ram1_work_done,
	input  wire                      reset,
	input  wire bus_pkg::wb_req_t    cpu_req,
	output bus_pkg::wb_rsp_t         cpu_rsp,
	output bus_pkg::wb_req_t         ram1_req,
	output bus_pkg::wb_req_t         ram2_req,
	output bus_pkg::wb_req_t         reg_req,
	input  wire bus_pkg::wb_rsp_t    ram1_rsp,
	input  wire bus_pkg::wb_rsp_t    ram2_rsp,
	input  wire bus_pkg::wb_rsp_t    reg_rsp
);

	bus_pkg::router_state_e state;
	mem_map_pkg::region_e   region_d;
	mem_map_pkg::region_e   region_q;
	bus_pkg::wb_req_t       req_q;
	logic                   down_stb;
	logic                   sel_ack;
	mem_map_pkg::data_t     sel_dat;
	mem_map_pkg::data_t     rsp_dat_q;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	// Register addresses sit in the RAM1 half, so they are checked first
	always_comb begin
		if (cpu_req.adr == mem_map_pkg::UART_DATA_ADDR) begin
			region_d = mem_map_pkg::REGION_UART_DATA;
		end else if (cpu_req.adr == mem_map_pkg::UART_STAT_ADDR) begin
			region_d = mem_map_pkg::REGION_UART_STAT;
		end else if (cpu_req.adr == mem_map_pkg::CFG_ADDR) begin
			region_d = mem_map_pkg::REGION_CFG;
		end else if (cpu_req.adr[15]) begin
			region_d = mem_map_pkg::REGION_RAM1;
		end else begin
			region_d = mem_map_pkg::REGION_RAM2;
		end
	end

	// Only the selected slave is listened to
	always_comb begin
		case (region_q)
			mem_map_pkg::REGION_RAM1: begin
				sel_ack = ram1_rsp.ack;
				sel_dat = ram1_rsp.dat;
			end
			mem_map_pkg::REGION_RAM2: begin
				sel_ack = ram2_rsp.ack;
				sel_dat = ram2_rsp.dat;
			end
			default: begin
				sel_ack = reg_rsp.ack;
				sel_dat = reg_rsp.dat;
			end
		endcase
	end

	// One downstream request at a time, strobe from the FSM
	always_comb begin
		ram1_req = '0;
		ram2_req = '0;
		reg_req  = '0;
		case (region_q)
			mem_map_pkg::REGION_RAM1: begin
				ram1_req     = req_q;
				ram1_req.cyc = down_stb;
				ram1_req.stb = down_stb;
			end
			mem_map_pkg::REGION_RAM2: begin
				ram2_req     = req_q;
				ram2_req.cyc = down_stb;
				ram2_req.stb = down_stb;
			end
			default: begin
				reg_req     = req_q;
				reg_req.cyc = down_stb;
				reg_req.stb = down_stb;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			state    <= bus_pkg::ST_IDLE;
			down_stb <= 1'b0;
		end else begin
			case (state)
				bus_pkg::ST_IDLE: begin
					if (cpu_req.cyc && cpu_req.stb) begin
						state <= bus_pkg::ST_WAIT;
					end
				end
				bus_pkg::ST_WAIT: begin
					// Strobe goes out one edge after the request is latched
					if (down_stb && sel_ack) begin
						down_stb <= 1'b0;
						state    <= bus_pkg::ST_RESPOND;
					end else if (!down_stb) begin
						down_stb <= 1'b1;
					end
				end
				bus_pkg::ST_RESPOND: begin
					state <= bus_pkg::ST_IDLE;
				end
				default: begin
					state    <= bus_pkg::ST_IDLE;
					down_stb <= 1'b0;
				end
			endcase
		end
	end

	// Request and response holding registers
	always_ff @(posedge ram1_work_done) begin
		if (state == bus_pkg::ST_IDLE && cpu_req.cyc && cpu_req.stb) begin
			req_q    <= cpu_req;
			region_q <= region_d;
		end
		if (state == bus_pkg::ST_WAIT && down_stb && sel_ack) begin
			rsp_dat_q <= sel_dat;
		end
	end

	assign cpu_rsp = '{dat: rsp_dat_q, ack: (state == bus_pkg::ST_RESPOND)};

endmodule

`default_nettype wire

/* source/mem_subsystem_top.sv */
`default_nettype none

module mem_subsystem_top #(
	parameter int RAM_DEPTH_LOG2 = 10
) (
	input  wire                      ram1_work_done,
	input  wire                      reset,
	input  wire bus_pkg::wb_req_t    cpu_req,
	output bus_pkg::wb_rsp_t         cpu_rsp,
	input  wire [7:0]                rx_byte,
	input  wire                      rx_strobe,
	output logic [7:0]               tx_byte,
	output logic                     tx_strobe
);

	bus_pkg::wb_req_t       ram1_req;
	bus_pkg::wb_req_t       ram2_req;
	bus_pkg::wb_req_t       reg_req;
	bus_pkg::wb_rsp_t       ram1_rsp;
	bus_pkg::wb_rsp_t       ram2_rsp;
	bus_pkg::wb_rsp_t       reg_rsp;
	mem_map_pkg::wait_cfg_t wait_cfg;

	mem_router i_router (
		.ram1_work_done (ram1_work_done),
		.reset          (reset),
		.cpu_req        (cpu_req),
		.cpu_rsp        (cpu_rsp),
		.ram1_req       (ram1_req),
		.ram2_req       (ram2_req),
		.reg_req        (reg_req),
		.ram1_rsp       (ram1_rsp),
		.ram2_rsp       (ram2_rsp),
		.reg_rsp        (reg_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Banks, upper half and lower half of the map
	////////////////////////////////////////////////////////////////////////////

	ram_bank #(.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)) i_ram1 (
		.ram1_work_done (ram1_work_done),
		.reset          (reset),
		.bank_req       (ram1_req),
		.bank_rsp       (ram1_rsp),
		.wait_count     (wait_cfg.ram1_wait)
	);

	ram_bank #(.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)) i_ram2 (
		.ram1_work_done (ram1_work_done),
		.reset          (reset),
		.bank_req       (ram2_req),
		.bank_rsp       (ram2_rsp),
		.wait_count     (wait_cfg.ram2_wait)
	);

	// UART and wait-state registers
	uart_cfg_regs i_regs (
		.ram1_work_done (ram1_work_done),
		.reset          (reset),
		.reg_req        (reg_req),
		.reg_rsp        (reg_rsp),
		.rx_byte        (rx_byte),
		.rx_strobe      (rx_strobe),
		.tx_byte        (tx_byte),
		.tx_strobe      (tx_strobe),
		.wait_cfg       (wait_cfg)
	);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic ram1_work_done,
	output logic reset
);

	initial begin
		ram1_work_done = 1'b0;
		forever #(PERIOD / 2) ram1_work_done = ~ram1_work_done;
	end

	// Reset drops a little after the last reset edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge ram1_work_done);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/mem_subsystem_tb.sv */
`default_nettype none

module mem_subsystem_tb;

	localparam int ACK_TIMEOUT = 50;

	logic                   ram1_work_done;
	logic                   reset;
	bus_pkg::wb_req_t       cpu_req;
	bus_pkg::wb_rsp_t       cpu_rsp;
	logic [7:0]             rx_byte;
	logic                   rx_strobe;
	logic [7:0]             tx_byte;
	logic                   tx_strobe;

	int                     errors;
	int                     checks;
	int                     tests;
	int                     test_errors;
	logic                   run_aborted;
	int                     tx_pulses = 0;
	int                     tx_pulses_seen;
	logic [7:0]             tx_last;
	mem_map_pkg::wait_cfg_t model_cfg;
	integer                 seed;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) i_clock_gen (
		.ram1_work_done (ram1_work_done),
		.reset          (reset)
	);

	mem_subsystem_top #(.RAM_DEPTH_LOG2(10)) i_dut (
		.ram1_work_done (ram1_work_done),
		.reset          (reset),
		.cpu_req        (cpu_req),
		.cpu_rsp        (cpu_rsp),
		.rx_byte        (rx_byte),
		.rx_strobe      (rx_strobe),
		.tx_byte        (tx_byte),
		.tx_strobe      (tx_strobe)
	);

	// Count tx strobes and keep the last byte sent
	always @(negedge ram1_work_done) begin
		if (!reset && tx_strobe === 1'b1) begin
			tx_pulses++;
			tx_last = tx_byte;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_data(input string name, input mem_map_pkg::data_t actual,
			input mem_map_pkg::data_t expected);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_cfg(input string name, input mem_map_pkg::wait_cfg_t actual,
			input mem_map_pkg::wait_cfg_t expected);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %0t %s: got ram1_wait %0d ram2_wait %0d, expected %0d %0d",
				$time, name, actual.ram1_wait, actual.ram2_wait,
				expected.ram1_wait, expected.ram2_wait);
			test_errors++;
		end
	endtask

	task automatic check_latency(input string name, input int actual, input int expected);
		checks++;
		if (actual != expected) begin
			$display("FAIL %0t %s: got %0d cycles, expected %0d", $time, name, actual, expected);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %b, expected %b", $time, name, actual, expected);
			test_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus and UART helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic next_drive_point();
		@(posedge ram1_work_done);
		#2;
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		test_errors++;
		run_aborted = 1'b1;
	endtask

	task automatic finish_test(input string label);
		tests++;
		errors += test_errors;
		$display("test %0d %s: %s", tests, label, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
	endtask

	// Cycles from the first edge with stb high to the edge that raises ack
	function automatic int expected_latency(input mem_map_pkg::addr_t adr);
		if (adr == mem_map_pkg::UART_DATA_ADDR || adr == mem_map_pkg::UART_STAT_ADDR
				|| adr == mem_map_pkg::CFG_ADDR) begin
			return 3;
		end
		if (adr[15]) begin
			return 3 + int'(model_cfg.ram1_wait);
		end
		return 3 + int'(model_cfg.ram2_wait);
	endfunction

	task automatic bus_access(input logic we, input mem_map_pkg::addr_t adr,
			input mem_map_pkg::data_t dat, output mem_map_pkg::data_t rdata,
			output int cycles, output logic acked);
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we  = we;
		cpu_req.adr = adr;
		cpu_req.dat = dat;
		cycles = 0;
		acked  = 1'b0;
		rdata  = '0;
		// Edge 0 of the access
		@(posedge ram1_work_done);
		while (!acked && cycles < ACK_TIMEOUT) begin
			@(negedge ram1_work_done);
			if (cpu_rsp.ack === 1'b1) begin
				acked = 1'b1;
				rdata = cpu_rsp.dat;
			end else begin
				@(posedge ram1_work_done);
				cycles++;
			end
		end
		next_drive_point();
		cpu_req = '0;
	endtask

	task automatic run_bus_op(input logic we, input mem_map_pkg::addr_t adr,
			input mem_map_pkg::data_t dat, input mem_map_pkg::data_t expected);
		mem_map_pkg::data_t rdata;
		int                 cycles;
		logic               acked;
		int                 latency_exp;
		latency_exp = expected_latency(adr);
		bus_access(we, adr, dat, rdata, cycles, acked);
		if (!acked) begin
			abort_run($sformatf("cpu acknowledge never came for address %h", adr));
		end else begin
			check_latency("cpu_rsp.ack latency", cycles, latency_exp);
			if (we && adr == mem_map_pkg::CFG_ADDR) begin
				model_cfg = mem_map_pkg::wait_cfg_t'(dat[7:0]);
			end else if (!we && adr == mem_map_pkg::CFG_ADDR) begin
				check_cfg("cpu_rsp.dat", mem_map_pkg::wait_cfg_t'(rdata[7:0]),
					mem_map_pkg::wait_cfg_t'(expected[7:0]));
			end else if (!we) begin
				check_data("cpu_rsp.dat", rdata, expected);
			end
		end
	endtask

	task automatic uart_receive(input logic [7:0] value);
		rx_byte   = value;
		rx_strobe = 1'b1;
		next_drive_point();
		rx_strobe = 1'b0;
	endtask

	task automatic check_tx(input mem_map_pkg::data_t expected);
		int cycles;
		int pulses;
		cycles = 0;
		while (tx_pulses == tx_pulses_seen && cycles < ACK_TIMEOUT) begin
			next_drive_point();
			cycles++;
		end
		pulses = tx_pulses - tx_pulses_seen;
		if (pulses == 0) begin
			abort_run("tx_strobe pulse never came");
		end else begin
			checks++;
			if (pulses != 1) begin
				$display("FAIL %0t tx_strobe pulses: got %0d, expected 1", $time, pulses);
				test_errors++;
			end
			check_data("tx_byte", {8'h00, tx_last}, expected);
			tx_pulses_seen = tx_pulses;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_sequence
		int                 fd;
		int                 code;
		int                 fields;
		int                 gap;
		int                 cycles;
		string              line;
		logic [7:0]         op;
		mem_map_pkg::addr_t adr;
		mem_map_pkg::data_t dat;
		mem_map_pkg::data_t expected;

		cpu_req        = '0;
		rx_byte        = '0;
		rx_strobe      = 1'b0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		test_errors    = 0;
		run_aborted    = 1'b0;
		tx_pulses_seen = 0;
		model_cfg      = '0;
		seed           = 32'h3e1e29cd;
		fd             = 0;

		// Wait for reset release
		cycles = 0;
		@(negedge ram1_work_done);
		while (reset && cycles < 10) begin
			@(negedge ram1_work_done);
			cycles++;
		end
		if (reset) begin
			abort_run("reset was never released");
		end else begin
			check_flag("cpu_rsp.ack", cpu_rsp.ack, 1'b0);
			check_flag("tx_strobe", tx_strobe, 1'b0);
		end
		finish_test("reset values");
		next_drive_point();

		if (!run_aborted) begin
			fd = $fopen("verification/mem_subsystem_testdata.txt", "r");
			if (fd == 0) begin
				abort_run("could not open the test data file");
				finish_test("test data file");
			end
		end

		while (!run_aborted && !$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%c %h %h %h", op, adr, dat, expected);
				if (fields == 4) begin
					case (op)
						"W": run_bus_op(1'b1, adr, dat, expected);
						"R": run_bus_op(1'b0, adr, dat, expected);
						"U": uart_receive(dat[7:0]);
						"C": check_tx(expected);
						default: begin
							$display("unknown operation %c in the test data file", op);
							test_errors++;
						end
					endcase
					finish_test($sformatf("%c %h", op, adr));
					// Idle gap between operations
					gap = $random(seed) & 3;
					repeat (gap) next_drive_point();
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/mem_map_pkg.sv
source/bus_pkg.sv
source/ram_bank.sv
source/uart_cfg_regs.sv
source/mem_router.sv
source/mem_subsystem_top.sv
verification/tb_clock_gen.sv
verification/mem_subsystem_tb.sv

/* verification/mem_subsystem_testdata.txt */
# op addr data expect, all hex
# W write, R read, U uart receive of the data byte, C check the tx byte
R BF02 0000 0000
W 8010 1111 0000
R 8010 0000 1111
W 8123 ABCD 0000
R 8123 0000 ABCD
W 0010 2222 0000
R 0010 0000 2222
R 8010 0000 1111
R 8410 0000 1111
R C010 0000 1111
R 4010 0000 2222
U 0000 00A5 0000
R BF01 0000 FFF7
R BF00 0000 00A5
R BF01 0000 FFF5
W BF00 1234 0000
C 0000 0000 0034
W BF00 00C3 0000
C 0000 0000 00C3
W BF02 0035 0000
R BF02 0000 0035
W 8030 5A5A 0000
R 8030 0000 5A5A
W 0030 A5A5 0000
R 0030 0000 A5A5
W BF02 00F0 0000
R BF02 0000 00F0
R 8123 0000 ABCD
R 0010 0000 2222
W BF02 0000 0000
R 8030 0000 5A5A
